// File: verilog/frontend_consts.svh
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// Datapath width of a PC or an instruction word
`define FE_XLEN 32

// Entries per buffer bank, two banks in total
`define FE_BANK_DEPTH 16

// Request to response delay of the instruction memory
`define FE_MEM_LATENCY 2

// Outstanding request queue depth
`define FE_REQ_DEPTH 4

// Opcodes seen by the predecoder
`define FE_OPC_BRANCH 7'b1100011
`define FE_OPC_JAL 7'b1101111

`endif

// File: verilog/frontend_pkg.sv
package frontend_pkg;

    ////////////////////////////////////////////////////////////
    // Basic words
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    ////////////////////////////////////////////////////////////
    // Predecode result per instruction
    ////////////////////////////////////////////////////////////

    // pre_target is zero for anything that is not a branch
    typedef struct packed {
        logic  is_branch;
        logic  pre_taken;
        addr_t pre_target;
    } branch_info_t;

    ////////////////////////////////////////////////////////////
    // Buffer payload
    ////////////////////////////////////////////////////////////

    // One instruction with its PC and prediction, 98 bits
    typedef struct packed {
        addr_t        pc;
        inst_t        inst;
        branch_info_t branch_info;
    } buf_entry_t;

    ////////////////////////////////////////////////////////////
    // Outstanding fetch request
    ////////////////////////////////////////////////////////////

    // Unaligned PC is kept so the response knows about a leading odd word
    typedef struct packed {
        addr_t pc;
        logic  epoch;
    } fetch_req_t;

endpackage

// File: verilog/fetch_push_if.sv
// Predecoded pair from the fetch unit into the instruction buffer
interface fetch_push_if;

    // Slot 0 is the older instruction, push_en is 00, 01 or 11
    logic [1:0] push_en;
    frontend_pkg::buf_entry_t [1:0] entry;

    // Buffer can absorb the current pair and everything in flight
    logic room;

    modport fetch_mp (
        output push_en,
        output entry,
        input  room
    );

    modport buf_mp (
        input  push_en,
        input  entry,
        output room
    );

endinterface

// File: verilog/sync_fifo.sv
`include "frontend_consts.svh"

module sync_fifo #(
    parameter type payload_t = frontend_pkg::fetch_req_t,
    parameter int DEPTH = `FE_REQ_DEPTH,
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int CNT_W = $clog2(DEPTH + 1)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush_i,
    input  logic             push_i,
    input  payload_t         push_data_i,
    input  logic             pop_i,
    output payload_t         pop_data_o,
    output logic             full_o,
    output logic             empty_o,
    output logic [CNT_W-1:0] free_o
);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign free_o  = CNT_W'(DEPTH) - count;

    // Head is read straight out of storage
    assign pop_data_o = mem[rd_ptr];

    assign do_pop  = pop_i && !empty_o;
    // A full FIFO still takes a push when the head leaves in the same cycle
    assign do_push = push_i && (!full_o || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/fetch_unit.sv
`include "frontend_consts.svh"

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  frontend_pkg::addr_t         flush_pc_i,
    output logic                        imem_req_o,
    output frontend_pkg::addr_t         imem_addr_o,
    input  frontend_pkg::inst_t [1:0]   imem_rdata_i,
    fetch_push_if.fetch_mp              push
);

    localparam int LAT = `FE_MEM_LATENCY;

    frontend_pkg::addr_t      fetch_pc;
    logic                     epoch;
    logic                     run_q;
    logic [LAT-1:0]           req_pipe;

    frontend_pkg::fetch_req_t req_new;
    frontend_pkg::fetch_req_t req_head;
    logic                     req_full;

    frontend_pkg::addr_t      pair_base;
    frontend_pkg::buf_entry_t slot [2];
    logic                     resp_ok;
    logic                     lead_skip;
    logic                     taken0;
    logic                     taken1;
    logic                     redirect;
    frontend_pkg::addr_t      redirect_pc;

    // Static rule: backward conditional branches and JAL are taken
    function automatic frontend_pkg::branch_info_t predecode(
        input frontend_pkg::addr_t pc,
        input frontend_pkg::inst_t inst
    );
        frontend_pkg::branch_info_t info;
        frontend_pkg::addr_t        offset;
        info   = '0;
        offset = '0;
        case (inst[6:0])
            `FE_OPC_BRANCH: begin
                info.is_branch = 1'b1;
                info.pre_taken = inst[31];
                offset = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            `FE_OPC_JAL: begin
                info.is_branch = 1'b1;
                info.pre_taken = 1'b1;
                offset = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                info.is_branch = 1'b0;
            end
        endcase
        if (info.is_branch) begin
            info.pre_target = pc + offset;
        end
        return info;
    endfunction

    ////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////

    // Holds fetch off until the first edge out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    assign imem_req_o  = run_q && push.room && !req_full;
    assign imem_addr_o = {fetch_pc[`FE_XLEN-1:3], 3'b000};

    assign req_new.pc    = fetch_pc;
    assign req_new.epoch = epoch;

    // Requests made before a flush are forgotten along with their responses
    sync_fifo #(
        .payload_t (frontend_pkg::fetch_req_t),
        .DEPTH     (`FE_REQ_DEPTH)
    ) req_q (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .push_i      (imem_req_o),
        .push_data_i (req_new),
        .pop_i       (req_pipe[LAT-1]),
        .pop_data_o  (req_head),
        .full_o      (req_full),
        .empty_o     (),
        .free_o      ()
    );

    // Marks the cycle in which each response is on imem_rdata_i
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            req_pipe <= '0;
        end else begin
            req_pipe <= {req_pipe[LAT-2:0], imem_req_o};
        end
    end

    ////////////////////////////////////////////////////////////
    // Response side
    ////////////////////////////////////////////////////////////

    assign pair_base = {req_head.pc[`FE_XLEN-1:3], 3'b000};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            slot[i].pc          = pair_base + frontend_pkg::addr_t'(4 * i);
            slot[i].inst        = imem_rdata_i[i];
            slot[i].branch_info = predecode(slot[i].pc, imem_rdata_i[i]);
        end
    end

    // Responses still in flight across a redirect carry the old epoch
    assign resp_ok   = req_pipe[LAT-1] && (req_head.epoch == epoch);
    // Target at PC 4 mod 8 leaves slot 0 outside the program path
    assign lead_skip = req_head.pc[2];

    // Older taken branch wins
    assign taken0 = !lead_skip && slot[0].branch_info.pre_taken;
    assign taken1 = !taken0 && slot[1].branch_info.pre_taken;

    assign redirect    = resp_ok && (taken0 || taken1);
    assign redirect_pc = taken0 ? slot[0].branch_info.pre_target
                                : slot[1].branch_info.pre_target;

    // A lone survivor always travels in slot 0
    assign push.entry[0]   = lead_skip ? slot[1] : slot[0];
    assign push.entry[1]   = slot[1];
    assign push.push_en[0] = resp_ok;
    assign push.push_en[1] = resp_ok && !lead_skip && !taken0;

    ////////////////////////////////////////////////////////////
    // Next fetch PC and epoch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= '0;
            epoch    <= 1'b0;
        end else if (flush_i) begin
            fetch_pc <= flush_pc_i;
            epoch    <= ~epoch;
        end else if (redirect) begin
            fetch_pc <= redirect_pc;
            epoch    <= ~epoch;
        end else if (imem_req_o) begin
            fetch_pc <= imem_addr_o + frontend_pkg::addr_t'(8);
        end
    end

endmodule

// File: verilog/inst_buffer.sv
`include "frontend_consts.svh"

module inst_buffer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush_i,
    input  logic                            stall_i,
    input  logic [1:0]                      issue_en_i,
    fetch_push_if.buf_mp                    push,
    output logic [1:0]                      out_valid_o,
    output frontend_pkg::buf_entry_t [1:0]  out_entry_o
);

    localparam int CNT_W = $clog2(`FE_BANK_DEPTH + 1);

    // Per bank, worst case is one entry from each pair not yet counted
    localparam int ROOM_MIN = `FE_MEM_LATENCY + 1;

    // Bank that takes the next older instruction, and bank holding the oldest
    logic wr_bank;
    logic rd_bank;

    logic                     bank_push  [2];
    frontend_pkg::buf_entry_t bank_wdata [2];
    logic                     bank_pop   [2];
    frontend_pkg::buf_entry_t bank_head  [2];
    logic                     bank_empty [2];
    logic [CNT_W-1:0]         bank_free  [2];
    logic [CNT_W-1:0]         min_free;

    logic pop0;
    logic pop1;

    ////////////////////////////////////////////////////////////
    // Bank steering on push and pop
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            if (b[0] == wr_bank) begin
                bank_push[b]  = push.push_en[0];
                bank_wdata[b] = push.entry[0];
            end else begin
                bank_push[b]  = push.push_en[1];
                bank_wdata[b] = push.entry[1];
            end
            bank_pop[b] = (b[0] == rd_bank) ? pop0 : pop1;
        end
    end

    for (genvar b = 0; b < 2; b++) begin : gen_bank
        sync_fifo #(
            .payload_t (frontend_pkg::buf_entry_t),
            .DEPTH     (`FE_BANK_DEPTH)
        ) bank (
            .clk         (clk),
            .rst         (rst),
            .flush_i     (flush_i),
            .push_i      (bank_push[b]),
            .push_data_i (bank_wdata[b]),
            .pop_i       (bank_pop[b]),
            .pop_data_o  (bank_head[b]),
            .full_o      (),
            .empty_o     (bank_empty[b]),
            .free_o      (bank_free[b])
        );
    end

    ////////////////////////////////////////////////////////////
    // Issue to decode
    ////////////////////////////////////////////////////////////

    assign out_entry_o[0] = bank_head[rd_bank];
    assign out_entry_o[1] = bank_head[~rd_bank];

    assign out_valid_o[0] = !bank_empty[rd_bank];
    // Younger slot only counts behind a valid older one
    assign out_valid_o[1] = out_valid_o[0] && !bank_empty[~rd_bank];

    assign pop0 = out_valid_o[0] && issue_en_i[0] && !stall_i;
    assign pop1 = pop0 && out_valid_o[1] && issue_en_i[1];

    // One instruction moves the pointer, two leave it in place
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
        end else begin
            wr_bank <= wr_bank ^ (push.push_en[0] ^ push.push_en[1]);
            rd_bank <= rd_bank ^ (pop0 ^ pop1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Space report to fetch
    ////////////////////////////////////////////////////////////

    assign min_free  = (bank_free[0] < bank_free[1]) ? bank_free[0] : bank_free[1];
    assign push.room = (min_free >= CNT_W'(ROOM_MIN));

endmodule

// File: verilog/frontend_top.sv
module frontend_top (
    input  logic                        clk,
    input  logic                        rst,

    // Instruction memory
    output logic                        imem_req_o,
    output frontend_pkg::addr_t         imem_addr_o,
    input  frontend_pkg::inst_t [1:0]   imem_rdata_i,

    // Back end
    input  logic                        flush_i,
    input  frontend_pkg::addr_t         flush_pc_i,
    input  logic                        stall_i,
    input  logic [1:0]                  issue_en_i,

    // Decode
    output logic [1:0]                  out_valid_o,
    output frontend_pkg::addr_t [1:0]   out_pc_o,
    output frontend_pkg::inst_t [1:0]   out_inst_o,
    output logic [1:0]                  out_is_branch_o,
    output logic [1:0]                  out_pre_taken_o,
    output frontend_pkg::addr_t [1:0]   out_pre_target_o
);

    frontend_pkg::buf_entry_t [1:0] out_entry;

    fetch_push_if push_bus ();

    fetch_unit u_fetch (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .flush_pc_i   (flush_pc_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .push         (push_bus.fetch_mp)
    );

    inst_buffer u_buffer (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .stall_i     (stall_i),
        .issue_en_i  (issue_en_i),
        .push        (push_bus.buf_mp),
        .out_valid_o (out_valid_o),
        .out_entry_o (out_entry)
    );

    // Flatten the issued entries for decode
    for (genvar i = 0; i < 2; i++) begin : gen_out
        assign out_pc_o[i]         = out_entry[i].pc;
        assign out_inst_o[i]       = out_entry[i].inst;
        assign out_is_branch_o[i]  = out_entry[i].branch_info.is_branch;
        assign out_pre_taken_o[i]  = out_entry[i].branch_info.pre_taken;
        assign out_pre_target_o[i] = out_entry[i].branch_info.pre_target;
    end

endmodule

// File: verification/tb_clock_gen.sv
// Free-running clock and a reset held over the first cycles
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // Reset drops on a falling edge like every other input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// File: verification/tb_frontend.sv
`include "frontend_consts.svh"

module tb_frontend;

    localparam int PERIOD        = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int RANDOM_CYCLES = 1500;
    localparam int HOLD_CYCLES   = 80;
    localparam int RESUME_CYCLES = 600;
    localparam int DRAIN_CYCLES  = 120;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + RANDOM_CYCLES + HOLD_CYCLES
                                 + RESUME_CYCLES + DRAIN_CYCLES + 8;
    localparam int LAT           = `FE_MEM_LATENCY;
    localparam int PROG_WORDS    = 256;
    localparam int MIN_ISSUED    = 500;
    localparam int KIND_NONE     = 0;
    localparam int KIND_COND     = 1;
    localparam int KIND_JAL      = 2;

    logic clk;
    logic rst;
    logic imem_req;
    frontend_pkg::addr_t imem_addr;
    frontend_pkg::inst_t [1:0] imem_rdata;
    logic flush;
    frontend_pkg::addr_t flush_pc;
    logic stall;
    logic [1:0] issue_en;
    logic [1:0] out_valid;
    frontend_pkg::addr_t [1:0] out_pc;
    frontend_pkg::inst_t [1:0] out_inst;
    logic [1:0] out_is_branch;
    logic [1:0] out_pre_taken;
    frontend_pkg::addr_t [1:0] out_pre_target;

    // Program image with a side table of branch kinds and offsets
    frontend_pkg::inst_t prog_mem [PROG_WORDS];
    int prog_kind [PROG_WORDS];
    int prog_off  [PROG_WORDS];

    // Memory response pipeline
    logic                resp_valid [LAT];
    frontend_pkg::addr_t resp_addr  [LAT];

    string phase = "reset";
    frontend_pkg::addr_t exp_pc = '0;
    logic flush_pending = 1'b0;
    frontend_pkg::addr_t pending_pc = '0;
    int error_count = 0;
    int issued_count = 0;
    int taken_count = 0;
    int not_taken_count = 0;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock0 (
        .clk_o (clk),
        .rst_o (rst)
    );

    frontend_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .imem_req_o       (imem_req),
        .imem_addr_o      (imem_addr),
        .imem_rdata_i     (imem_rdata),
        .flush_i          (flush),
        .flush_pc_i       (flush_pc),
        .stall_i          (stall),
        .issue_en_i       (issue_en),
        .out_valid_o      (out_valid),
        .out_pc_o         (out_pc),
        .out_inst_o       (out_inst),
        .out_is_branch_o  (out_is_branch),
        .out_pre_taken_o  (out_pre_taken),
        .out_pre_target_o (out_pre_target)
    );

    ////////////////////////////////////////////////////////////
    // Program image and memory model
    ////////////////////////////////////////////////////////////

    // OP-IMM words whose upper bits follow the whole address
    function automatic frontend_pkg::inst_t filler_word(input frontend_pkg::addr_t addr);
        return {addr[31:7] ^ addr[26:2], 7'b0010011};
    endfunction

    function automatic frontend_pkg::inst_t encode_branch(input int offset, input logic [2:0] f3);
        logic [12:0] imm;
        imm = offset[12:0];
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `FE_OPC_BRANCH};
    endfunction

    function automatic frontend_pkg::inst_t encode_jal(input int offset);
        logic [20:0] imm;
        imm = offset[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `FE_OPC_JAL};
    endfunction

    task automatic place_branch(input frontend_pkg::addr_t pc, input int offset,
                                input logic [2:0] f3);
        prog_mem[pc[9:2]]  = encode_branch(offset, f3);
        prog_kind[pc[9:2]] = KIND_COND;
        prog_off[pc[9:2]]  = offset;
    endtask

    task automatic place_jal(input frontend_pkg::addr_t pc, input int offset);
        prog_mem[pc[9:2]]  = encode_jal(offset);
        prog_kind[pc[9:2]] = KIND_JAL;
        prog_off[pc[9:2]]  = offset;
    endtask

    // Main loop 0x00-0x20, 0x64-0x7c, 0x40-0x50, 0xa0-0xf0, back to 0
    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_mem[i]  = filler_word(frontend_pkg::addr_t'(4 * i));
            prog_kind[i] = KIND_NONE;
            prog_off[i]  = 0;
        end
        place_branch(32'h010, 16, 3'b000);
        place_jal(32'h020, 32'h44);
        place_branch(32'h07c, -60, 3'b001);
        place_jal(32'h050, 32'h50);
        place_branch(32'h0b8, 32, 3'b100);
        place_jal(32'h0f0, -240);
    endtask

    function automatic frontend_pkg::inst_t mem_word(input frontend_pkg::addr_t addr);
        if (addr < frontend_pkg::addr_t'(PROG_WORDS * 4)) begin
            return prog_mem[addr[9:2]];
        end else begin
            return filler_word(addr);
        end
    endfunction

    // Pair data appears in the cycle two requests later
    always @(negedge clk) begin
        if (resp_valid[LAT-1] === 1'b1) begin
            imem_rdata[0] = mem_word(resp_addr[LAT-1]);
            imem_rdata[1] = mem_word(resp_addr[LAT-1] + 32'd4);
        end else begin
            imem_rdata = '0;
        end
        for (int i = LAT - 1; i > 0; i--) begin
            resp_valid[i] = resp_valid[i-1];
            resp_addr[i]  = resp_addr[i-1];
        end
        resp_valid[0] = (imem_req === 1'b1);
        resp_addr[0]  = imem_addr;
    end

    ////////////////////////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////////////////////////

    function automatic frontend_pkg::buf_entry_t expected_entry(input frontend_pkg::addr_t pc);
        frontend_pkg::buf_entry_t e;
        int kind;
        int offset;
        e      = '0;
        kind   = KIND_NONE;
        offset = 0;
        e.pc   = pc;
        e.inst = mem_word(pc);
        if (pc < frontend_pkg::addr_t'(PROG_WORDS * 4)) begin
            kind   = prog_kind[pc[9:2]];
            offset = prog_off[pc[9:2]];
        end
        if (kind != KIND_NONE) begin
            e.branch_info.is_branch  = 1'b1;
            e.branch_info.pre_taken  = (kind == KIND_JAL) || (offset < 0);
            e.branch_info.pre_target = pc + frontend_pkg::addr_t'(offset);
        end
        return e;
    endfunction

    function automatic frontend_pkg::addr_t expected_next_pc(input frontend_pkg::buf_entry_t e);
        if (e.branch_info.pre_taken) begin
            return e.branch_info.pre_target;
        end else begin
            return e.pc + 32'd4;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_issued_slot(input int slot);
        frontend_pkg::buf_entry_t e;
        e = expected_entry(exp_pc);
        check_value({phase, " pc"}, e.pc, out_pc[slot]);
        check_value({phase, " inst"}, e.inst, out_inst[slot]);
        check_value({phase, " is_branch"}, e.branch_info.is_branch, out_is_branch[slot]);
        check_value({phase, " pre_taken"}, e.branch_info.pre_taken, out_pre_taken[slot]);
        check_value({phase, " pre_target"}, e.branch_info.pre_target, out_pre_target[slot]);
        if (e.branch_info.is_branch && e.branch_info.pre_taken) begin
            taken_count++;
        end else if (e.branch_info.is_branch) begin
            not_taken_count++;
        end
        issued_count++;
        exp_pc = expected_next_pc(e);
    endtask

    // Instructions leave at the edge where slot 0 is valid, enabled and not stalled
    always @(posedge clk) begin
        if (rst === 1'b0) begin
            if (flush === 1'b1) begin
                exp_pc = flush_pc;
            end else if (!stall && issue_en[0] && out_valid[0]) begin
                check_issued_slot(0);
                if (issue_en[1] && out_valid[1]) begin
                    check_issued_slot(1);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    function automatic frontend_pkg::addr_t flush_target(input int idx);
        case (idx)
            0: return 32'h000;
            1: return 32'h044;
            2: return 32'h0a8;
            3: return 32'h0b4;
            default: return 32'h300;
        endcase
    endfunction

    task automatic drive_inputs(input logic st, input logic [1:0] iss, input logic fl,
                                input frontend_pkg::addr_t fpc);
        // Restart request goes out in the cycle after a flush
        if (flush_pending) begin
            check_value("flush_restart req", 1, imem_req);
            check_value("flush_restart addr", {pending_pc[31:3], 3'b000}, imem_addr);
        end
        flush_pending = fl;
        pending_pc    = fpc;
        stall    = st;
        issue_en = iss;
        flush    = fl;
        flush_pc = fpc;
    endtask

    task automatic drive_random_cycle();
        int r;
        logic st;
        logic [1:0] iss;
        logic fl;
        st = ($urandom_range(0, 99) < 15);
        r  = $urandom_range(0, 9);
        if (r < 2) begin
            iss = 2'b00;
        end else if (r < 5) begin
            iss = 2'b01;
        end else if (r < 6) begin
            iss = 2'b10;
        end else begin
            iss = 2'b11;
        end
        fl = ($urandom_range(0, 249) == 0);
        if (fl) begin
            iss = 2'b00;
        end
        drive_inputs(st, iss, fl, flush_target($urandom_range(0, 4)));
    endtask

    initial begin
        void'($urandom(62));
        stall      = 1'b0;
        issue_en   = 2'b00;
        flush      = 1'b0;
        flush_pc   = '0;
        imem_rdata = '0;
        load_program();

        repeat (3) @(negedge clk);
        check_value("reset_state req", 0, imem_req);
        check_value("reset_state valid", 0, out_valid);
        wait (rst === 1'b0);
        @(negedge clk);
        check_value("reset_vector req", 1, imem_req);
        check_value("reset_vector addr", 0, imem_addr);

        phase = "random_issue";
        repeat (RANDOM_CYCLES) begin
            @(negedge clk);
            drive_random_cycle();
        end

        // Decode holds off until the buffer fills and fetch pauses
        phase = "buffer_fill";
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            drive_inputs(1'b0, 2'b00, 1'b0, '0);
        end
        check_value("buffer_fill req_paused", 0, imem_req);
        check_value("buffer_fill valid", 2'b11, out_valid);

        phase = "resume";
        repeat (RESUME_CYCLES) begin
            @(negedge clk);
            drive_random_cycle();
        end

        phase = "flush";
        @(negedge clk);
        drive_inputs(1'b0, 2'b00, 1'b1, 32'h0b4);

        phase = "drain";
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            drive_inputs(1'b0, 2'b11, 1'b0, '0);
        end
        @(negedge clk);

        if (issued_count < MIN_ISSUED) begin
            $display("Too few instructions were issued: %0d", issued_count);
            error_count++;
        end
        if (taken_count == 0 || not_taken_count == 0) begin
            $display("Taken and not-taken branches were not both issued");
            error_count++;
        end
        $display("Summary: %0d instructions checked, %0d errors", issued_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(longint'(TOTAL_CYCLES) * 4 * PERIOD);
        $display("Watchdog expired before the stimulus finished");
        $display("Summary: %0d instructions checked, %0d errors", issued_count, error_count);
        $display("Errors found");
        $finish;
    end

endmodule

// File: frontend_top.f
+incdir+verilog
verilog/frontend_pkg.sv
verilog/fetch_push_if.sv
verilog/sync_fifo.sv
verilog/fetch_unit.sv
verilog/inst_buffer.sv
verilog/frontend_top.sv
verification/tb_clock_gen.sv
verification/tb_frontend.sv

// File: Bender.yml
package:
  name: frontend

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/frontend_pkg.sv
      - verilog/fetch_push_if.sv
      - verilog/sync_fifo.sv
      - verilog/fetch_unit.sv
      - verilog/inst_buffer.sv
      - verilog/frontend_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_frontend.sv
